//--- simt_core.f
+incdir+src
src/simt_pkg.sv
src/simt_if.sv
src/simt_gpr_bank.sv
src/simt_decode.sv
src/simt_operands.sv
src/simt_alu.sv
src/simt_result.sv
src/simt_core.sv
dv/simt_core_tb.sv

//--- dv/simt_core_tb.sv
// SIMT slice testbench
`timescale 1ns/1ns
`include "simt_defs.svh"

module simt_core_tb;
    import simt_pkg::*;

    typedef struct packed {
        logic [`SIMT_WARP_BITS-1:0] warp;
        logic [`SIMT_REG_BITS-1:0]  rd;
        logic [`SIMT_NUM_LANES-1:0] tmask;
        logic                       wb;
        lane_data_t                 data;
    } exp_t;

    logic clk;
    logic reset;
    logic in_valid;
    logic in_ready;
    logic [`SIMT_WARP_BITS-1:0] in_warp;
    logic [`SIMT_NUM_LANES-1:0] in_tmask;
    instr_t in_instr;
    logic res_valid;
    logic res_ready;
    logic [`SIMT_WARP_BITS-1:0] res_warp;
    logic [`SIMT_REG_BITS-1:0] res_rd;
    logic [`SIMT_NUM_LANES-1:0] res_tmask;
    logic res_wb;
    lane_data_t res_data;

    logic random_ready;
    logic [31:0] stim_lfsr = 32'd10004;
    logic [31:0] ready_lfsr = 32'd10004;
    logic [`SIMT_XLEN-1:0] model_regs [`SIMT_NUM_WARPS][`SIMT_NUM_REGS][`SIMT_NUM_LANES];
    exp_t exp_q[$];

    simt_core dut0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_warp   (in_warp),
        .in_tmask  (in_tmask),
        .in_instr  (in_instr),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_warp  (res_warp),
        .res_rd    (res_rd),
        .res_tmask (res_tmask),
        .res_wb    (res_wb),
        .res_data  (res_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] r_word(input logic [3:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [4:0] rs3);
        return {op, rd, rs1, rs2, rs3, 8'h00};
    endfunction

    function automatic logic [31:0] i_word(input logic [3:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [17:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (expected === actual) else report_failure($sformatf(
            "[ERROR] t=%0t %s expected %h got %h", $time, name, expected, actual));
    endtask

    function automatic logic [`SIMT_XLEN-1:0] read_reg(input int w, input int r, input int lane);
        return (r == 0) ? '0 : model_regs[w][r][lane];
    endfunction

    // the model runs each instruction in acceptance order, on all lanes
    task automatic record_expected(input logic [1:0] w, input logic [3:0] m,
                                   input logic [31:0] word);
        exp_t e;
        logic [3:0] op;
        logic [4:0] rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] imm;
        op = word[31:28];
        rd = word[27:23];
        imm = {{14{word[17]}}, word[17:0]};
        e.warp = w;
        e.rd = rd;
        e.tmask = m;
        e.wb = (op < 4'd8) && (rd != 5'd0);
        for (int lane = 0; lane < `SIMT_NUM_LANES; lane++) begin
            a = read_reg(w, word[22:18], lane);
            b = read_reg(w, word[17:13], lane);
            c = read_reg(w, word[12:8], lane);
            case (op)
                4'd0: e.data[lane] = a + b;
                4'd1: e.data[lane] = a - b;
                4'd2: e.data[lane] = a & b;
                4'd3: e.data[lane] = a ^ b;
                4'd4: e.data[lane] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                4'd5: e.data[lane] = a * b + c;
                4'd6: e.data[lane] = a + imm;
                4'd7: e.data[lane] = imm;
                default: e.data[lane] = '0;
            endcase
        end
        // inactive lanes keep their old value
        for (int lane = 0; lane < `SIMT_NUM_LANES; lane++) begin
            if (e.wb && m[lane]) begin
                model_regs[w][rd][lane] = e.data[lane];
            end
        end
        exp_q.push_back(e);
    endtask

    // called at a falling edge and returns at the falling edge after the transfer
    task automatic send_instr(input logic [1:0] w, input logic [3:0] m, input logic [31:0] word);
        int cnt;
        in_valid = 1'b1;
        in_warp = w;
        in_tmask = m;
        in_instr = word;
        cnt = 0;
        #1;
        while (!in_ready) begin
            @(negedge clk);
            #1;
            cnt++;
            assert (cnt < 1000) else report_failure("timed out waiting for in_ready");
        end
        record_expected(w, m, word);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic send_random(input logic any_op);
        logic [1:0] w;
        logic [3:0] m;
        logic [3:0] op;
        logic [27:0] rest;
        w = rand_bits(2);
        m = rand_bits(4);
        op = rand_bits(4);
        rest = rand_bits(28);
        if (!any_op) begin
            op[3] = 1'b0;
        end
        send_instr(w, m, {op, rest});
    endtask

    initial begin : result_checker
        exp_t e;
        logic stalled;
        lane_data_t held_data;
        res_ready = 1'b1;
        stalled = 1'b0;
        held_data = '0;
        forever begin
            @(negedge clk);
            // a stalled result must still be there, unchanged
            if (stalled) begin
                assert (res_valid === 1'b1) else
                    report_failure("res_valid dropped while res_ready was low");
                check_field("res_data", held_data, res_data);
            end
            if (random_ready) begin
                ready_lfsr = lfsr_step(ready_lfsr);
                res_ready = ready_lfsr[0];
            end else begin
                res_ready = 1'b1;
            end
            stalled = (res_valid === 1'b1) && !res_ready;
            held_data = res_data;
            if (res_valid === 1'b1 && res_ready) begin
                assert (exp_q.size() > 0) else
                    report_failure("a result appeared with no instruction outstanding");
                e = exp_q.pop_front();
                check_field("res_warp", e.warp, res_warp);
                check_field("res_rd", e.rd, res_rd);
                check_field("res_tmask", e.tmask, res_tmask);
                check_field("res_wb", e.wb, res_wb);
                check_field("res_data", e.data, res_data);
            end
        end
    end

    initial begin
        int cnt;
        reset = 1'b1;
        in_valid = 1'b0;
        in_warp = '0;
        in_tmask = '0;
        in_instr = '0;
        random_ready = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int w = 0; w < `SIMT_NUM_WARPS; w++) begin
            for (int r = 1; r < `SIMT_NUM_REGS; r++) begin
                send_instr(2'(w), 4'hf, i_word(MOVI, 5'(r), 5'd0, 18'(rand_bits(18))));
            end
        end

        repeat (200) send_random(1'b0);

        // register 0 as a source and as a destination
        send_instr(2'd0, 4'hf, r_word(ADD, 5'd5, 5'd0, 5'd3, 5'd0));
        send_instr(2'd1, 4'hf, i_word(ADDI, 5'd0, 5'd4, 18'h00123));
        send_instr(2'd2, 4'hf, r_word(MAD, 5'd6, 5'd2, 5'd0, 5'd0));
        send_instr(2'd3, 4'h5, r_word(SUB, 5'd7, 5'd0, 5'd8, 5'd0));
        send_instr(2'd1, 4'hf, r_word(ADD, 5'd9, 5'd0, 5'd0, 5'd0));

        repeat (8) send_instr(2'd1, 4'hf, i_word(ADDI, 5'd7, 5'd7, 18'h3));
        for (int k = 0; k < 12; k++) begin
            send_instr(2'(k), 4'hf, r_word(ADD, 5'd9, 5'd9, 5'd9, 5'd0));
        end

        // reserved codes, each followed by a read of its rd
        for (int k = 8; k < 16; k++) begin
            send_instr(2'(k), 4'(rand_bits(4)), r_word(4'(k), 5'(k), 5'd1, 5'd2, 5'd3));
            send_instr(2'(k), 4'hf, i_word(ADDI, 5'(k), 5'(k), 18'h0));
        end

        random_ready = 1'b1;
        repeat (150) send_random(1'b1);

        cnt = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            cnt++;
            assert (cnt < 5000) else report_failure("timed out waiting for outstanding results");
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- src/simt_core.sv
// SIMT execution slice
`timescale 1ns/1ns
`include "simt_defs.svh"

module simt_core (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [`SIMT_WARP_BITS-1:0] in_warp,
    input  logic [`SIMT_NUM_LANES-1:0] in_tmask,
    input  simt_pkg::instr_t           in_instr,
    output logic                       res_valid,
    input  logic                       res_ready,
    output logic [`SIMT_WARP_BITS-1:0] res_warp,
    output logic [`SIMT_REG_BITS-1:0]  res_rd,
    output logic [`SIMT_NUM_LANES-1:0] res_tmask,
    output logic                       res_wb,
    output simt_pkg::lane_data_t       res_data
);
    uop_if  issue_if ();
    exec_if opnd_if ();
    exec_if alu_if ();
    wb_if   wb_bus ();

    simt_decode decode0 (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_warp  (in_warp),
        .in_tmask (in_tmask),
        .in_instr (in_instr),
        .issue    (issue_if.src),
        .wb       (wb_bus.sb_dst)
    );

    simt_operands operands0 (
        .clk   (clk),
        .reset (reset),
        .issue (issue_if.dst),
        .exec  (opnd_if.src),
        .wb    (wb_bus.bank_dst)
    );

    simt_alu alu0 (
        .clk      (clk),
        .reset    (reset),
        .exec_in  (opnd_if.dst),
        .exec_out (alu_if.src)
    );

    simt_result result0 (
        .clk       (clk),
        .reset     (reset),
        .exec_in   (alu_if.dst),
        .wb        (wb_bus.src),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_warp  (res_warp),
        .res_rd    (res_rd),
        .res_tmask (res_tmask),
        .res_wb    (res_wb),
        .res_data  (res_data)
    );

endmodule

//--- src/simt_result.sv
// SIMT result and writeback
`timescale 1ns/1ns
`include "simt_defs.svh"

module simt_result (
    input  logic                       clk,
    input  logic                       reset,
    exec_if.dst                        exec_in,
    wb_if.src                          wb,
    output logic                       res_valid,
    input  logic                       res_ready,
    output logic [`SIMT_WARP_BITS-1:0] res_warp,
    output logic [`SIMT_REG_BITS-1:0]  res_rd,
    output logic [`SIMT_NUM_LANES-1:0] res_tmask,
    output logic                       res_wb,
    output simt_pkg::lane_data_t       res_data
);
    import simt_pkg::*;

    uop_t res_uop;
    logic accept;

    assign exec_in.ready = !res_valid || res_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (exec_in.ready) begin
            res_valid <= exec_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_in.valid && exec_in.ready) begin
            res_uop <= exec_in.uop;
            res_data <= exec_in.rs1_data;
        end
    end

    assign res_warp = res_uop.warp;
    assign res_rd = res_uop.rd;
    assign res_tmask = res_uop.tmask;
    assign res_wb = res_uop.wb;

    // registers and scoreboard update on the edge the result is taken
    assign accept = res_valid && res_ready;
    assign wb.valid = accept && res_uop.wb;
    assign wb.warp = res_uop.warp;
    assign wb.rd = res_uop.rd;
    assign wb.tmask = res_uop.tmask;
    assign wb.data = res_data;

    a_res_stable: assert property (@(posedge clk) disable iff (reset)
        res_valid && !res_ready |=> res_valid && $stable(res_data));

endmodule

//--- src/simt_alu.sv
// SIMT lane-parallel ALU
`timescale 1ns/1ns
`include "simt_defs.svh"

module simt_alu (
    input  logic clk,
    input  logic reset,
    exec_if.dst  exec_in,
    exec_if.src  exec_out
);
    import simt_pkg::*;

    logic out_valid;
    uop_t out_uop;
    lane_data_t result;
    lane_data_t out_data;
    logic fire;

    assign exec_in.ready = !out_valid || exec_out.ready;
    assign fire = exec_in.valid && exec_in.ready;

    always_comb begin
        logic [`SIMT_XLEN-1:0] a;
        logic [`SIMT_XLEN-1:0] b;
        logic [`SIMT_XLEN-1:0] c;
        for (int lane = 0; lane < `SIMT_NUM_LANES; lane++) begin
            a = exec_in.rs1_data[lane];
            // the immediate takes the place of rs2
            b = exec_in.uop.use_imm ? exec_in.uop.imm : exec_in.rs2_data[lane];
            c = exec_in.rs3_data[lane];
            case (exec_in.uop.op)
                ADD, ADDI: result[lane] = a + b;
                SUB:       result[lane] = a - b;
                AND:       result[lane] = a & b;
                XOR:       result[lane] = a ^ b;
                SLT:       result[lane] = ($signed(a) < $signed(b)) ? `SIMT_XLEN'(1) : '0;
                MAD:       result[lane] = a * b + c;
                MOVI:      result[lane] = b;
                default:   result[lane] = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (exec_in.ready) begin
            out_valid <= exec_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_uop <= exec_in.uop;
            out_data <= result;
        end
    end

    assign exec_out.valid = out_valid;
    assign exec_out.uop = out_uop;
    assign exec_out.rs1_data = out_data;
    assign exec_out.rs2_data = '0;
    assign exec_out.rs3_data = '0;

endmodule

//--- src/simt_operands.sv
// SIMT operand collector
`timescale 1ns/1ns
`include "simt_defs.svh"

module simt_operands (
    input  logic   clk,
    input  logic   reset,
    uop_if.dst     issue,
    exec_if.src    exec,
    wb_if.bank_dst wb
);
    import simt_pkg::*;

    typedef enum logic [1:0] {
        idle,
        fetch1,
        fetch2,
        fetch3
    } state_t;

    state_t state;
    state_t state_n;
    logic stg_valid;
    uop_t stg_uop;
    lane_data_t rs1_data;
    lane_data_t rs2_data;
    lane_data_t rs3_data;
    lane_data_t gpr_rdata;
    logic [`SIMT_WARP_BITS-1:0] rd_warp;
    logic [`SIMT_REG_BITS-1:0] rd_reg;
    logic [`SIMT_GPR_ADDR_BITS-1:0] rd_addr;
    logic [`SIMT_GPR_ADDR_BITS-1:0] wr_addr;
    logic accept;
    logic drain;
    logic done;

    assign drain = exec.valid && exec.ready;
    assign issue.ready = (state == idle) && (!stg_valid || exec.ready);
    assign accept = issue.valid && issue.ready;

    // rd_reg is the register the banks sample on the coming edge
    always_comb begin
        state_n = state;
        done = 1'b0;
        rd_warp = stg_uop.warp;
        rd_reg = '0;
        case (state)
            idle: begin
                rd_warp = issue.uop.warp;
                if (accept) begin
                    if (issue.uop.rs1 != '0) begin
                        state_n = fetch1;
                        rd_reg = issue.uop.rs1;
                    end else if (issue.uop.rs2 != '0) begin
                        state_n = fetch2;
                        rd_reg = issue.uop.rs2;
                    end else if (issue.uop.rs3 != '0) begin
                        state_n = fetch3;
                        rd_reg = issue.uop.rs3;
                    end else begin
                        done = 1'b1;
                    end
                end
            end
            fetch1: begin
                if (stg_uop.rs2 != '0) begin
                    state_n = fetch2;
                    rd_reg = stg_uop.rs2;
                end else if (stg_uop.rs3 != '0) begin
                    state_n = fetch3;
                    rd_reg = stg_uop.rs3;
                end else begin
                    state_n = idle;
                    done = 1'b1;
                end
            end
            fetch2: begin
                if (stg_uop.rs3 != '0) begin
                    state_n = fetch3;
                    rd_reg = stg_uop.rs3;
                end else begin
                    state_n = idle;
                    done = 1'b1;
                end
            end
            fetch3: begin
                state_n = idle;
                done = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            stg_valid <= 1'b0;
        end else begin
            state <= state_n;
            if (done) begin
                stg_valid <= 1'b1;
            end else if (drain) begin
                stg_valid <= 1'b0;
            end
        end
    end

    // skipped sources keep the zero loaded at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            stg_uop <= issue.uop;
            rs1_data <= '0;
            rs2_data <= '0;
            rs3_data <= '0;
        end
        case (state)
            fetch1: rs1_data <= gpr_rdata;
            fetch2: rs2_data <= gpr_rdata;
            fetch3: rs3_data <= gpr_rdata;
            default: ;
        endcase
    end

    assign exec.valid = stg_valid;
    assign exec.uop = stg_uop;
    assign exec.rs1_data = rs1_data;
    assign exec.rs2_data = rs2_data;
    assign exec.rs3_data = rs3_data;

    assign rd_addr = {rd_warp, rd_reg};
    assign wr_addr = {wb.warp, wb.rd};

    for (genvar lane = 0; lane < `SIMT_NUM_LANES; lane++) begin : g_lane
        simt_gpr_bank bank (
            .clk   (clk),
            .write (wb.valid && wb.tmask[lane]),
            .waddr (wr_addr),
            .wdata (wb.data[lane]),
            .raddr (rd_addr),
            .rdata (gpr_rdata[lane])
        );
    end

    // a new uop is only collected once the staging register has room
    a_no_fetch_while_stalled: assert property (@(posedge clk) disable iff (reset)
        stg_valid && !exec.ready |-> state == idle);

endmodule

//--- src/simt_decode.sv
// SIMT instruction decode
`timescale 1ns/1ns
`include "simt_defs.svh"

module simt_decode (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [`SIMT_WARP_BITS-1:0] in_warp,
    input  logic [`SIMT_NUM_LANES-1:0] in_tmask,
    input  simt_pkg::instr_t           in_instr,
    uop_if.src                         issue,
    wb_if.sb_dst                       wb
);
    import simt_pkg::*;

    uop_t dec_uop;
    uop_t out_uop;
    logic out_valid;
    logic hazard;
    logic fire;
    logic [`SIMT_NUM_WARPS-1:0][`SIMT_NUM_REGS-1:0] pending;

    always_comb begin
        dec_uop = '0;
        dec_uop.warp = in_warp;
        dec_uop.tmask = in_tmask;
        dec_uop.op = in_instr.r.op;
        dec_uop.rd = in_instr.r.rd;
        case (in_instr.r.op)
            ADD, SUB, AND, XOR, SLT: begin
                dec_uop.rs1 = in_instr.r.rs1;
                dec_uop.rs2 = in_instr.r.rs2;
                dec_uop.wb = 1'b1;
            end
            MAD: begin
                dec_uop.rs1 = in_instr.r.rs1;
                dec_uop.rs2 = in_instr.r.rs2;
                dec_uop.rs3 = in_instr.r.rs3;
                dec_uop.wb = 1'b1;
            end
            ADDI, MOVI: begin
                if (in_instr.i.op == ADDI) begin
                    dec_uop.rs1 = in_instr.i.rs1;
                end
                dec_uop.use_imm = 1'b1;
                dec_uop.imm = `SIMT_XLEN'(signed'(in_instr.i.imm));
                dec_uop.wb = 1'b1;
            end
            default: begin
                dec_uop.wb = 1'b0;
            end
        endcase
        // register 0 is never written
        if (dec_uop.rd == '0) begin
            dec_uop.wb = 1'b0;
        end
    end

    // unused sources were zeroed, and register 0 is never marked pending
    assign hazard = pending[out_uop.warp][out_uop.rs1] | pending[out_uop.warp][out_uop.rs2]
                  | pending[out_uop.warp][out_uop.rs3] | pending[out_uop.warp][out_uop.rd];

    assign issue.valid = out_valid && !hazard;
    assign issue.uop = out_uop;
    assign fire = issue.valid && issue.ready;
    assign in_ready = !out_valid || fire;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            pending <= '0;
        end else begin
            if (in_valid && in_ready) begin
                out_valid <= 1'b1;
            end else if (fire) begin
                out_valid <= 1'b0;
            end
            if (wb.valid) begin
                pending[wb.warp][wb.rd] <= 1'b0;
            end
            if (fire && out_uop.wb) begin
                pending[out_uop.warp][out_uop.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_uop <= dec_uop;
        end
    end

    // a writeback only ever releases a register marked pending here
    a_release_pending: assert property (@(posedge clk) disable iff (reset)
        wb.valid |-> pending[wb.warp][wb.rd]);

endmodule

//--- src/simt_gpr_bank.sv
// SIMT lane register bank
`timescale 1ns/1ns
`include "simt_defs.svh"

module simt_gpr_bank (
    input  logic                           clk,
    input  logic                           write,
    input  logic [`SIMT_GPR_ADDR_BITS-1:0] waddr,
    input  logic [`SIMT_XLEN-1:0]          wdata,
    input  logic [`SIMT_GPR_ADDR_BITS-1:0] raddr,
    output logic [`SIMT_XLEN-1:0]          rdata
);
    localparam int DEPTH = `SIMT_NUM_REGS * `SIMT_NUM_WARPS;

    logic [`SIMT_XLEN-1:0] mem [DEPTH];

    // a read of the address being written returns the old word
    always_ff @(posedge clk) begin
        if (write) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

//--- src/simt_if.sv
// SIMT stage interfaces
`timescale 1ns/1ns
`include "simt_defs.svh"

interface uop_if;
    import simt_pkg::*;

    logic valid;
    logic ready;
    uop_t uop;

    modport src (output valid, output uop, input ready);
    modport dst (input valid, input uop, output ready);
endinterface

// after the ALU only rs1_data is meaningful and holds the result
interface exec_if;
    import simt_pkg::*;

    logic       valid;
    logic       ready;
    uop_t       uop;
    lane_data_t rs1_data;
    lane_data_t rs2_data;
    lane_data_t rs3_data;

    modport src (output valid, output uop, output rs1_data, output rs2_data,
                 output rs3_data, input ready);
    modport dst (input valid, input uop, input rs1_data, input rs2_data,
                 input rs3_data, output ready);
endinterface

interface wb_if;
    import simt_pkg::*;

    logic                       valid;
    logic [`SIMT_WARP_BITS-1:0] warp;
    logic [`SIMT_REG_BITS-1:0]  rd;
    logic [`SIMT_NUM_LANES-1:0] tmask;
    lane_data_t                 data;

    modport src (output valid, output warp, output rd, output tmask, output data);
    modport bank_dst (input valid, input warp, input rd, input tmask, input data);
    modport sb_dst (input valid, input warp, input rd);
endinterface

//--- src/simt_pkg.sv
// SIMT slice types
`include "simt_defs.svh"

package simt_pkg;

    // codes 8 to 15 are reserved and produce no writeback
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        XOR  = 4'd3,
        SLT  = 4'd4,
        MAD  = 4'd5,
        ADDI = 4'd6,
        MOVI = 4'd7
    } opcode_t;

    typedef struct packed {
        opcode_t                   op;
        logic [`SIMT_REG_BITS-1:0] rd;
        logic [`SIMT_REG_BITS-1:0] rs1;
        logic [`SIMT_REG_BITS-1:0] rs2;
        logic [`SIMT_REG_BITS-1:0] rs3;
        logic [7:0]                unused;
    } instr_r_t;

    typedef struct packed {
        opcode_t                   op;
        logic [`SIMT_REG_BITS-1:0] rd;
        logic [`SIMT_REG_BITS-1:0] rs1;
        logic [17:0]               imm;
    } instr_i_t;

    // the same word seen in register form or immediate form
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

    typedef struct packed {
        logic [`SIMT_WARP_BITS-1:0] warp;
        logic [`SIMT_NUM_LANES-1:0] tmask;
        opcode_t                    op;
        logic [`SIMT_REG_BITS-1:0]  rd;
        logic [`SIMT_REG_BITS-1:0]  rs1;
        logic [`SIMT_REG_BITS-1:0]  rs2;
        logic [`SIMT_REG_BITS-1:0]  rs3;
        logic                       use_imm;
        logic [`SIMT_XLEN-1:0]      imm;
        logic                       wb;
    } uop_t;

    typedef logic [`SIMT_NUM_LANES-1:0][`SIMT_XLEN-1:0] lane_data_t;

endpackage

//--- src/simt_defs.svh
// SIMT slice parameters
`ifndef SIMT_DEFS_SVH
`define SIMT_DEFS_SVH

// lanes per warp, one register bank each
`define SIMT_NUM_LANES 4

`define SIMT_XLEN 32

// architectural registers per warp
`define SIMT_NUM_REGS 32

`define SIMT_NUM_WARPS 4

// log2 of the register and warp counts
`define SIMT_REG_BITS 5
`define SIMT_WARP_BITS 2

// a bank is addressed by warp and register together
`define SIMT_GPR_ADDR_BITS (`SIMT_WARP_BITS + `SIMT_REG_BITS)

`endif
